// File: hdl/dataMem_consts.svh
// Data memory sizing constants
// Lane count, depth in words and the word-index width that follows from it

`ifndef DATAMEM_CONSTS_SVH
`define DATAMEM_CONSTS_SVH

// ------------------------------
// Geometry
// ------------------------------
`define DM_LANES        4           // Byte lanes per 32-bit word
`define DM_DEPTH_WORDS  256         // Words held by each lane

// ------------------------------
// Addressing
// ------------------------------
// Must satisfy 2**DM_INDEX_BITS == DM_DEPTH_WORDS
`define DM_INDEX_BITS   8           // Word-index width, addr[2 +: 8]

`endif

// File: hdl/memOpPkg.sv
// Memory operation types
// Opcode enum for the load/store port and the decoded access descriptor

package memOpPkg;

    // ------------------------------
    // Opcodes
    // ------------------------------
    typedef enum logic [2:0] {
        opByteSigned   = 3'b000,    // lb / sb
        opHalfSigned   = 3'b001,    // lh / sh
        opWord         = 3'b010,    // lw / sw
        opByteUnsigned = 3'b100,    // lbu, load only
        opHalfUnsigned = 3'b101     // lhu, load only
    } memOp_t;

    // Access size codes carried in accessDesc_t.size
    localparam logic [1:0] sizeByte = 2'd0;
    localparam logic [1:0] sizeHalf = 2'd1;
    localparam logic [1:0] sizeWord = 2'd2;

    // ------------------------------
    // Decoded access
    // ------------------------------
    typedef struct packed {
        logic       valid;          // Defined code and aligned address
        logic [1:0] size;           // sizeByte, sizeHalf or sizeWord
        logic       isSigned;       // Sign-extend on load
        logic [1:0] byteOffset;     // addr[1:0]
    } accessDesc_t;

endpackage

// File: hdl/laneTypesPkg.sv
// Byte lane types
// Lane data byte and the word index shared by all lanes

`include "dataMem_consts.svh"

package laneTypesPkg;

    // ------------------------------
    // Lane data
    // ------------------------------
    typedef logic [7:0] laneByte_t;                         // One byte of a word

    // ------------------------------
    // Lane addressing
    // ------------------------------
    // Same index goes to every lane, so one word is one row across lanes
    typedef logic [`DM_INDEX_BITS-1:0] wordIndex_t;

endpackage

// File: hdl/laneBus.sv
// Byte lane bus
// Joins the store steering block, one storage lane and the load extension block

`timescale 1ns/1ps

interface laneBus
    import laneTypesPkg::*;
();

    wordIndex_t index;          // Word row within the lane
    logic       laneWrEn;       // Store this lane's byte at the next edge
    laneByte_t  wrByte;         // Byte to store
    laneByte_t  rdByte;         // Byte currently held at index

    // ------------------------------
    // Views
    // ------------------------------
    modport steer (
        output index,
        output laneWrEn,
        output wrByte
    );

    modport lane (
        input  index,
        input  laneWrEn,
        input  wrByte,
        output rdByte
    );

    modport drain (
        input  rdByte
    );

endinterface

// File: hdl/storeSteer.sv
// Store steering
// Decodes the opcode and low address bits, flags misaligned accesses,
// and drives word index, lane write enables and write bytes to each lane

`timescale 1ns/1ps

`include "dataMem_consts.svh"

module storeSteer
    import memOpPkg::*;
    import laneTypesPkg::*;
(
    input  logic        reset,
    input  logic        wrEn,
    input  memOp_t      memOp,
    input  logic [31:0] addr,
    input  logic [31:0] dataIn,
    laneBus.steer       lanes [0:`DM_LANES-1],
    output accessDesc_t desc,
    output logic        misaligned
);

    logic                 codeOk;       // memOp is one of the five defined codes
    logic                 isStoreCode;  // Signed byte, signed half or word
    logic [1:0]           accSize;
    logic                 accSigned;
    logic                 aligned;
    logic                 writeGo;
    logic [`DM_LANES-1:0] laneMask;
    logic [31:0]          steerWord;
    wordIndex_t           wordIndex;

    // ------------------------------
    // Opcode decode
    // ------------------------------
    always_comb begin
        codeOk      = 1'b1;
        isStoreCode = 1'b0;
        accSize     = sizeByte;
        accSigned   = 1'b0;
        case (memOp)
            opByteSigned: begin
                accSigned   = 1'b1;
                isStoreCode = 1'b1;
            end
            opHalfSigned: begin
                accSize     = sizeHalf;
                accSigned   = 1'b1;
                isStoreCode = 1'b1;
            end
            opWord: begin
                accSize     = sizeWord;
                isStoreCode = 1'b1;
            end
            opByteUnsigned: accSize = sizeByte;
            opHalfUnsigned: accSize = sizeHalf;
            default:        codeOk  = 1'b0;     // Undefined code reads zero, writes nothing
        endcase
    end

    // Halfword needs an even address, word a multiple of four
    always_comb begin
        case (accSize)
            sizeHalf: aligned = ~addr[0];
            sizeWord: aligned = (addr[1:0] == 2'b00);
            default:  aligned = 1'b1;
        endcase
    end

    assign misaligned      = codeOk & ~aligned;
    assign desc.valid      = codeOk & aligned;
    assign desc.size       = accSize;
    assign desc.isSigned   = accSigned;
    assign desc.byteOffset = addr[1:0];

    // ------------------------------
    // Write steering
    // ------------------------------
    assign wordIndex = addr[2 +: `DM_INDEX_BITS];     // Upper bits dropped, aliases
    assign writeGo   = wrEn & ~reset & isStoreCode & desc.valid;

    // Replicate the payload so lane i always finds its byte at steerWord[8*i +: 8]
    always_comb begin
        case (accSize)
            sizeByte: begin
                laneMask  = 4'b0001 << addr[1:0];
                steerWord = {4{dataIn[7:0]}};
            end
            sizeHalf: begin
                laneMask  = 4'b0011 << addr[1:0];
                steerWord = {2{dataIn[15:0]}};
            end
            default: begin
                laneMask  = 4'b1111;
                steerWord = dataIn;
            end
        endcase
    end

    for (genvar i = 0; i < `DM_LANES; i++) begin : gLaneDrive
        assign lanes[i].index    = wordIndex;
        assign lanes[i].laneWrEn = writeGo & laneMask[i];
        assign lanes[i].wrByte   = steerWord[8*i +: 8];
    end

endmodule

// File: hdl/memLane.sv
// Byte storage lane
// One byte per word row, written on the clock edge and read combinationally

`timescale 1ns/1ps

`include "dataMem_consts.svh"

module memLane
    import laneTypesPkg::*;
(
    input  logic clk,
    laneBus.lane bus
);

    // ------------------------------
    // Storage
    // ------------------------------
    laneByte_t mem [0:`DM_DEPTH_WORDS-1];   // Contents undefined until written

    always_ff @(posedge clk) begin
        if (bus.laneWrEn) begin
            mem[bus.index] <= bus.wrByte;   // Visible to reads after this edge
        end
    end

    // ------------------------------
    // Read port
    // ------------------------------
    // Same-cycle read of a row being written still sees the old byte
    assign bus.rdByte = mem[bus.index];

endmodule

// File: hdl/loadExtend.sv
// Load extension
// Gathers the lane read bytes into a word, picks the addressed byte or
// halfword, and sign- or zero-extends it to 32 bits

`timescale 1ns/1ps

`include "dataMem_consts.svh"

module loadExtend
    import memOpPkg::*;
    import laneTypesPkg::*;
(
    laneBus.drain       lanes [0:`DM_LANES-1],
    input  accessDesc_t desc,
    output logic [31:0] dataOut
);

    logic [31:0] rdWord;
    logic [31:0] shifted;
    laneByte_t   selByte;
    logic [15:0] selHalf;
    logic        byteFill;
    logic        halfFill;

    // ------------------------------
    // Word assembly
    // ------------------------------
    for (genvar i = 0; i < `DM_LANES; i++) begin : gLaneGather
        assign rdWord[8*i +: 8] = lanes[i].rdByte;
    end

    // Bring the addressed byte down to bit 0
    assign shifted = rdWord >> {desc.byteOffset, 3'b000};
    assign selByte = shifted[7:0];
    assign selHalf = shifted[15:0];

    // ------------------------------
    // Extension
    // ------------------------------
    assign byteFill = desc.isSigned & selByte[7];
    assign halfFill = desc.isSigned & selHalf[15];

    always_comb begin
        dataOut = '0;                       // Undefined or misaligned reads as zero
        if (desc.valid) begin
            case (desc.size)
                sizeByte: dataOut = {{24{byteFill}}, selByte};
                sizeHalf: dataOut = {{16{halfFill}}, selHalf};
                sizeWord: dataOut = rdWord;
                default:  dataOut = '0;
            endcase
        end
    end

endmodule

// File: hdl/dataMem.sv
// Byte-lane data memory
// Load/store port with combinational sign/zero-extended loads and
// byte, halfword and word stores on the next rising clock edge

`timescale 1ns/1ps

`include "dataMem_consts.svh"

module dataMem
    import memOpPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        wrEn,
    input  logic [2:0]  memOp,
    input  logic [31:0] addr,
    input  logic [31:0] dataIn,
    output logic [31:0] dataOut,
    output logic        misaligned
);

    accessDesc_t desc;                      // Decoded access, steer to extend

    // ------------------------------
    // Lane buses
    // ------------------------------
    laneBus laneIf [0:`DM_LANES-1] ();

    // ------------------------------
    // Decode and write steering
    // ------------------------------
    storeSteer steer0 (
        .reset      (reset),
        .wrEn       (wrEn),
        .memOp      (memOp_t'(memOp)),      // Undefined codes pass through as-is
        .addr       (addr),
        .dataIn     (dataIn),
        .lanes      (laneIf),
        .desc       (desc),
        .misaligned (misaligned)
    );

    // ------------------------------
    // Storage lanes
    // ------------------------------
    for (genvar i = 0; i < `DM_LANES; i++) begin : gLane
        memLane lane (
            .clk (clk),
            .bus (laneIf[i])
        );
    end

    // ------------------------------
    // Read extension
    // ------------------------------
    loadExtend extend0 (
        .lanes   (laneIf),
        .desc    (desc),
        .dataOut (dataOut)
    );

endmodule

// File: test/dataMem_properties.sv
// Data memory port properties
// Concurrent checks on the load port, bound into the top level

`timescale 1ns/1ps

module dataMem_properties (
    input logic        clk,
    input logic [2:0]  memOp,
    input logic [31:0] addr,
    input logic [31:0] dataOut,
    input logic        misaligned
);

    int unsigned failCount = 0;         // Polled by the testbench

    logic undefCode;
    logic expectMis;

    assign undefCode = (memOp == 3'b011) || (memOp == 3'b110) || (memOp == 3'b111);

    // Halfword codes end in 01, word is 010
    assign expectMis = ((memOp[1:0] == 2'b01) && addr[0]) ||
                       ((memOp == 3'b010) && (addr[1:0] != 2'b00));

    // ------------------------------
    // Load port rules
    // ------------------------------
    aMisReadsZero: assert property (@(posedge clk) misaligned |-> (dataOut == 32'h0))
        else begin
            failCount++;
            $error("misaligned access returned data %h", dataOut);
        end

    aMisRule: assert property (@(posedge clk) misaligned == expectMis)
        else begin
            failCount++;
            $error("misaligned flag %b for op %b addr %h", misaligned, memOp, addr);
        end

    aUndefZero: assert property (@(posedge clk) undefCode |-> (dataOut == 32'h0))
        else begin
            failCount++;
            $error("undefined op %b returned data %h", memOp, dataOut);
        end

    // Sign fill must be uniform above the loaded byte or halfword
    aByteSignFill: assert property (@(posedge clk) (memOp == 3'b000) |->
            ((dataOut[31:8] == 24'h0) || (dataOut[31:8] == 24'hFF_FFFF)))
        else begin
            failCount++;
            $error("signed byte load has mixed upper bits %h", dataOut);
        end

    aHalfSignFill: assert property (@(posedge clk) (memOp == 3'b001) |->
            ((dataOut[31:16] == 16'h0) || (dataOut[31:16] == 16'hFFFF)))
        else begin
            failCount++;
            $error("signed halfword load has mixed upper bits %h", dataOut);
        end

endmodule

bind dataMem dataMem_properties props0 (
    .clk        (clk),
    .memOp      (memOp),
    .addr       (addr),
    .dataOut    (dataOut),
    .misaligned (misaligned)
);

// File: test/dataMemTb.sv
// Data memory testbench
// Directed and random load/store traffic checked against a byte-array
// model, with a mid-run reset pulse and a cycle timeout

`timescale 1ns/1ps

`include "dataMem_consts.svh"

module dataMemTb
    import memOpPkg::*;
();

    localparam int ClkHalf       = 10;
    localparam int TestCycles    = 2000;
    localparam int TimeoutCycles = 2 * TestCycles;
    localparam int RandomCycles  = 1960;
    localparam int PulseAt       = 900;                 // Mid-run reset pulse start
    localparam int ModelBytes    = `DM_DEPTH_WORDS * `DM_LANES;
    localparam int AddrBits      = `DM_INDEX_BITS + 2;
    localparam logic [32:0] MisResult = 33'h1_0000_0000;

    logic        clk;
    logic        reset;
    logic        wrEn;
    logic [2:0]  memOp;
    logic [31:0] addr;
    logic [31:0] dataIn;
    logic [31:0] dataOut;
    logic        misaligned;

    logic [7:0]  model [0:ModelBytes-1];                // Shadow of the whole array
    logic [31:0] lcgState;
    int          cycleCount = 0;

    dataMem dut0 (
        .clk        (clk),
        .reset      (reset),
        .wrEn       (wrEn),
        .memOp      (memOp),
        .addr       (addr),
        .dataIn     (dataIn),
        .dataOut    (dataOut),
        .misaligned (misaligned)
    );

    initial begin
        clk = 1'b0;
        forever #ClkHalf clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the run went past %0d clock cycles", TimeoutCycles);
            $display("TEST FAIL");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] randomWord();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic failCheck(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    // Returns {misaligned, dataOut} as the port rules give them
    function automatic logic [32:0] expectLoad(input logic [2:0] op, input logic [31:0] a);
        logic [AddrBits-1:0] base;
        logic [7:0]          b0;
        logic [15:0]         h0;
        logic [31:0]         w0;
        base = a[AddrBits-1:0];                         // Upper bits alias away
        b0   = model[base];
        h0   = {model[base + AddrBits'(1)], model[base]};
        w0   = {model[base + AddrBits'(3)], model[base + AddrBits'(2)], h0};
        case (op)
            opByteSigned:   return {1'b0, {24{b0[7]}}, b0};
            opByteUnsigned: return {1'b0, 24'h0, b0};
            opHalfSigned:   return a[0] ? MisResult : {1'b0, {16{h0[15]}}, h0};
            opHalfUnsigned: return a[0] ? MisResult : {1'b0, 16'h0, h0};
            opWord:         return (a[1:0] != 2'b00) ? MisResult : {1'b0, w0};
            default:        return 33'h0;
        endcase
    endfunction

    task automatic storeModel(input logic rst, input logic we, input logic [2:0] op,
                              input logic [31:0] a, input logic [31:0] d);
        logic [AddrBits-1:0] base;
        base = a[AddrBits-1:0];
        if (!rst && we) begin
            case (op)
                opByteSigned: model[base] = d[7:0];
                opHalfSigned: begin
                    if (!a[0]) begin
                        model[base]                = d[7:0];
                        model[base + AddrBits'(1)] = d[15:8];
                    end
                end
                opWord: begin
                    if (a[1:0] == 2'b00) begin
                        model[base]                = d[7:0];
                        model[base + AddrBits'(1)] = d[15:8];
                        model[base + AddrBits'(2)] = d[23:16];
                        model[base + AddrBits'(3)] = d[31:24];
                    end
                end
                default: ;                              // Unsigned and undefined codes store nothing
            endcase
        end
    endtask

    // One access: drive on the falling edge, check just before the rising edge
    task automatic runCycle(input logic rst, input logic we, input logic [2:0] op,
                            input logic [31:0] a, input logic [31:0] d, input bit doCheck);
        logic [32:0] expected;
        @(negedge clk);
        reset  = rst;
        wrEn   = we;
        memOp  = op;
        addr   = a;
        dataIn = d;
        #(ClkHalf - 1);
        if (dut0.props0.failCount != 0) begin
            $display("A concurrent assertion on the memory ports failed");
            $display("TEST FAIL");
            $fatal(1, "Stopped on a property failure");
        end
        expected = expectLoad(op, a);
        if (doCheck) begin
            assert (misaligned === expected[32]) else failCheck($sformatf(
                "misaligned %b, expected %b, op %b addr %h", misaligned, expected[32], op, a));
            assert (dataOut === expected[31:0]) else failCheck($sformatf(
                "dataOut %h, expected %h, op %b addr %h", dataOut, expected[31:0], op, a));
        end
        storeModel(rst, we, op, a, d);                  // Takes effect at the coming edge
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] a;
        logic        rst;
        reset    = 1'b1;
        wrEn     = 1'b0;
        memOp    = opWord;
        addr     = 32'h0;
        dataIn   = 32'h0;
        lcgState = 32'h4486;

        for (int i = 0; i < 3; i++) begin              // Store attempts while in reset
            runCycle(1'b1, 1'b1, opWord, 32'(4 * i), 32'hDEAD_0000 + 32'(i), 1'b0);
        end
        for (int w = 0; w < 16; w++) begin             // Fill the 64 bytes in use
            runCycle(1'b0, 1'b1, opWord, 32'(4 * w),
                     {8'(w) ^ 8'hC3, 8'(w * 7), ~8'(w), 8'(w) + 8'h5A}, 1'b0);
        end

        runCycle(1'b1, 1'b1, opWord, 32'h10, 32'hDEAD_BEEF, 1'b1);   // Blocked by reset
        runCycle(1'b0, 1'b0, opWord, 32'h10, 32'h0, 1'b1);

        runCycle(1'b0, 1'b1, opWord, 32'h8, 32'h80FF_7F01, 1'b1);   // Same cycle sees old word
        runCycle(1'b0, 1'b0, opWord, 32'h8, 32'h0, 1'b1);
        runCycle(1'b0, 1'b0, opByteSigned, 32'hA, 32'h0, 1'b1);
        runCycle(1'b0, 1'b0, opByteUnsigned, 32'hB, 32'h0, 1'b1);
        runCycle(1'b0, 1'b0, opHalfSigned, 32'hA, 32'h0, 1'b1);
        runCycle(1'b0, 1'b0, opHalfUnsigned, 32'hA, 32'h0, 1'b1);
        runCycle(1'b0, 1'b1, opByteSigned, 32'h409, 32'h0000_00AA, 1'b1);  // Aliases to 0x9
        runCycle(1'b0, 1'b1, opHalfSigned, 32'hB, 32'h0000_1234, 1'b1);    // Misaligned
        runCycle(1'b0, 1'b1, opHalfUnsigned, 32'hA, 32'h0000_5678, 1'b1);
        runCycle(1'b0, 1'b1, 3'b111, 32'h8, 32'hFFFF_FFFF, 1'b1);
        runCycle(1'b0, 1'b0, opWord, 32'h8, 32'h0, 1'b1);

        for (int n = 0; n < RandomCycles; n++) begin
            r0 = randomWord();
            r1 = randomWord();
            r2 = randomWord();
            a = {26'h0, r1[5:0]};
            if (r0[6]) begin
                a[31:AddrBits] = r1[31:AddrBits];       // Same bytes, aliased address
            end
            rst = (n >= PulseAt) && (n < PulseAt + 3);
            runCycle(rst, r0[4] | r0[5], r0[2:0], a, r2, 1'b1);
        end

        @(posedge clk);
        @(negedge clk);
        if (dut0.props0.failCount == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("A concurrent assertion failed in the last cycle");
            $display("TEST FAIL");
            $fatal(1, "Stopped on a property failure");
        end
    end

endmodule

// File: dataMem.f
+incdir+hdl
hdl/memOpPkg.sv
hdl/laneTypesPkg.sv
hdl/laneBus.sv
hdl/storeSteer.sv
hdl/memLane.sv
hdl/loadExtend.sv
hdl/dataMem.sv
test/dataMem_properties.sv
test/dataMemTb.sv

// File: Makefile
# Verilator build and run for the byte-lane data memory

TOP = dataMemTb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the run log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f dataMem.f --top-module $(TOP) \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "^TEST PASS$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
